//--- include/memctl_consts.svh
//====================================================================
// address map and sizes of the shared memory controller
// include wherever widths or counts are needed
//====================================================================
`ifndef MEMCTL_CONSTS_SVH
`define MEMCTL_CONSTS_SVH

`define MEMCTL_CLIENTS       4   // cpu, sprite, bg, flash
`define MEMCTL_ADDR_W        16  // 64K words shared space
`define MEMCTL_DATA_W        16  // word width
`define MEMCTL_BANKS         4   // picked by top address bits
`define MEMCTL_BANK_ADDR_W   14  // 16K words per bank
`define MEMCTL_BOOT_ADDR_W   8   // 256-word boot overlay

// bank select sits right above the in-bank address
// boot window is where the upper address bits are all zero

`endif

//--- hdl/memctl_pkg.sv
//====================================================================
// shared types for the memory controller RTL
// modules import it in the body, ports use scoped names
//====================================================================
`default_nettype none

`include "memctl_consts.svh"

package memctl_pkg;

	typedef logic [$clog2(`MEMCTL_CLIENTS)-1:0] client_idx_t; // client number

	localparam client_idx_t CLIENT_CPU    = 2'd0; // reads and writes
	localparam client_idx_t CLIENT_SPRITE = 2'd1; // read only
	localparam client_idx_t CLIENT_BG     = 2'd2; // read only
	localparam client_idx_t CLIENT_FLASH  = 2'd3; // write only

	typedef struct packed {
		logic [`MEMCTL_ADDR_W-1:0] addr;  // word address
		logic [`MEMCTL_DATA_W-1:0] wdata; // ignored on reads
		logic                      wr;    // 1 = write
	} mem_req_t;

	typedef struct packed {
		logic [`MEMCTL_DATA_W-1:0] rdata; // read result
	} mem_rsp_t;

	typedef struct packed {
		logic [`MEMCTL_BANK_ADDR_W-1:0] addr; // address inside bank
		logic [`MEMCTL_DATA_W-1:0]      wdata;
		logic                           we;   // write strobe
	} bank_port_t;

	typedef enum logic [1:0] {
		IDLE,    // nothing granted
		ACCESS,  // ready out, bank access issued
		RESPOND  // read data back
	} arb_state_t;

endpackage

`default_nettype wire

//--- hdl/mem_bank.sv
//====================================================================
// one 16K-word single-port memory bank
// write on the clock edge, read data registered one cycle later
//====================================================================
`default_nettype none
`timescale 1ns/1ns

`include "memctl_consts.svh"

module mem_bank (
	input  wire memctl_pkg::bank_port_t  port,   // address, data, strobe
	input  wire logic                    CLK,
	output logic [`MEMCTL_DATA_W-1:0]    rdata   // valid cycle after access
);

	localparam int WORDS = 1 << `MEMCTL_BANK_ADDR_W; // 16K

	logic [`MEMCTL_DATA_W-1:0] mem [WORDS]; // block ram, starts undefined

	// read-before-write, keeps the array mappable onto block ram
	always_ff @(posedge CLK)
	begin
		if (port.we)
		begin
			mem[port.addr] <= port.wdata; // write strobe from router
		end
		rdata <= mem[port.addr]; // registered read port
	end

endmodule

`default_nettype wire

//--- hdl/boot_overlay.sv
//====================================================================
// small writable boot memory over the lowest 256 words, CPU only
// picks boot or bank data in the response cycle
//====================================================================
`default_nettype none
`timescale 1ns/1ns

`include "memctl_consts.svh"

module boot_overlay (
	input  wire logic                    CLK,
	input  wire memctl_pkg::mem_req_t    req,        // granted request
	input  wire logic                    en,         // access cycle
	input  wire logic                    is_cpu,     // grant belongs to cpu
	input  wire logic [`MEMCTL_DATA_W-1:0] bank_rdata, // data from router
	output logic                         boot_hit,   // cpu in boot window
	output logic [`MEMCTL_DATA_W-1:0]    rdata       // to all clients
);

	localparam int BOOT_WORDS = 1 << `MEMCTL_BOOT_ADDR_W; // 256

	logic [`MEMCTL_DATA_W-1:0]      boot_mem [BOOT_WORDS]; // no init contents
	logic [`MEMCTL_DATA_W-1:0]      boot_q;    // registered boot read
	logic                           hit_q;     // hit seen in access cycle
	logic [`MEMCTL_BOOT_ADDR_W-1:0] boot_addr;

	assign boot_addr = req.addr[`MEMCTL_BOOT_ADDR_W-1:0]; // low byte
	// upper address bits all zero and cpu granted
	assign boot_hit = is_cpu &&
		(req.addr[`MEMCTL_ADDR_W-1:`MEMCTL_BOOT_ADDR_W] == '0);

	always_ff @(posedge CLK)
	begin
		if (en && boot_hit && req.wr)
		begin
			boot_mem[boot_addr] <= req.wdata; // bank write is blocked meanwhile
		end
		boot_q <= boot_mem[boot_addr]; // same latency as the banks
		hit_q  <= boot_hit;            // lines up with returning data
	end

	// response cycle select
	assign rdata = hit_q ? boot_q : bank_rdata;

endmodule

`default_nettype wire

//--- hdl/grant_rotator.sv
//====================================================================
// round-robin priority pointer for the arbiter
// moves past the last served client at each accept
//====================================================================
`default_nettype none
`timescale 1ns/1ns

`include "memctl_consts.svh"

module grant_rotator (
	input  wire logic                    CLK,
	input  wire logic                    rst,
	input  wire logic                    access_done, // accept edge
	input  wire memctl_pkg::client_idx_t grant,       // client just served
	output memctl_pkg::client_idx_t      prio         // search start
);

	import memctl_pkg::*;

	client_idx_t prio_nxt; // wraps after the last client

	// served client drops to lowest priority
	assign prio_nxt = grant + client_idx_t'(1);

	always_ff @(posedge CLK)
	begin
		if (rst)
		begin
			prio <= CLIENT_CPU; // cpu first after reset
		end
		else if (access_done)
		begin
			prio <= prio_nxt;
		end
	end

	// with four clients the 2-bit add wraps on its own, so every client
	// asking keeps getting served once per four accesses

endmodule

`default_nettype wire

//--- hdl/arb_fsm.sv
//====================================================================
// arbiter state machine, one access every two cycles under load
// grants the first valid client at or after the priority pointer
//====================================================================
`default_nettype none
`timescale 1ns/1ns

`include "memctl_consts.svh"

module arb_fsm (
	input  wire logic                      CLK,
	input  wire logic                      rst,
	input  wire logic [`MEMCTL_CLIENTS-1:0] req_valid,
	input  wire logic [`MEMCTL_CLIENTS-1:0] req_wr,  // per-client write flag
	input  wire memctl_pkg::client_idx_t   prio,     // from rotator
	output logic [`MEMCTL_CLIENTS-1:0]     req_ready, // one cycle, one client
	output logic [`MEMCTL_CLIENTS-1:0]     rsp_valid, // reads only
	output memctl_pkg::client_idx_t        grant,
	output logic                           grant_valid, // access cycle
	output logic                           access_done  // advances rotator
);

	import memctl_pkg::*;

	arb_state_t  state;
	arb_state_t  state_nxt;
	client_idx_t pick;     // winner for the next grant
	logic        any_req;
	logic        wr_q;     // latched write flag of grant

	// first valid client at or after start, wrapping
	function automatic client_idx_t pick_next(input logic [`MEMCTL_CLIENTS-1:0] valid,
		input client_idx_t start);
		client_idx_t idx;
		client_idx_t sel;
		logic        found;
		sel   = start;
		found = 1'b0;
		for (int i = 0; i < `MEMCTL_CLIENTS; i++)
		begin
			idx = start + client_idx_t'(i); // wraps at 4
			if (!found && valid[idx])
			begin
				sel   = idx;
				found = 1'b1;
			end
		end
		return sel;
	endfunction

	assign any_req = |req_valid;
	assign pick    = pick_next(req_valid, prio);

	always_comb
	begin
		case (state)
			IDLE:    state_nxt = any_req ? ACCESS : IDLE;
			ACCESS:  state_nxt = RESPOND; // accept edge
			RESPOND: state_nxt = any_req ? ACCESS : IDLE; // back to back
			default: state_nxt = IDLE;
		endcase
	end

	always_ff @(posedge CLK)
	begin
		if (rst)
		begin
			state <= IDLE;
			grant <= CLIENT_CPU;
			wr_q  <= 1'b0;
		end
		else
		begin
			state <= state_nxt;
			if ((state != ACCESS) && any_req)
			begin
				grant <= pick;         // held through access and respond
				wr_q  <= req_wr[pick]; // no response for writes
			end
		end
	end

	assign grant_valid = (state == ACCESS); // bank or boot access issued
	assign access_done = (state == ACCESS); // rotator moves on the accept edge

	always_comb
	begin
		req_ready = '0;
		rsp_valid = '0;
		if (state == ACCESS)
		begin
			req_ready[grant] = 1'b1;
		end
		if ((state == RESPOND) && !wr_q)
		begin
			rsp_valid[grant] = 1'b1; // data registered by now
		end
	end

endmodule

`default_nettype wire

//--- hdl/bank_router.sv
//====================================================================
// steers the granted request onto one of four banks by addr[15:14]
// and brings back that bank's read data a cycle later
//====================================================================
`default_nettype none
`timescale 1ns/1ns

`include "memctl_consts.svh"

module bank_router (
	input  wire logic                   CLK,
	input  wire logic                   rst,
	input  wire memctl_pkg::mem_req_t   req,      // granted request
	input  wire logic                   en,       // access cycle
	input  wire logic                   boot_hit, // cpu boot access
	output memctl_pkg::bank_port_t [`MEMCTL_BANKS-1:0] bank,
	input  wire logic [`MEMCTL_BANKS-1:0][`MEMCTL_DATA_W-1:0] bank_rdata,
	output logic [`MEMCTL_DATA_W-1:0]   rdata     // selected bank data
);

	localparam int SEL_W = $clog2(`MEMCTL_BANKS); // 2 select bits

	logic [SEL_W-1:0] sel;   // bank of current request
	logic [SEL_W-1:0] sel_q; // bank of the access in flight

	assign sel = req.addr[`MEMCTL_ADDR_W-1 -: SEL_W]; // addr[15:14]

	// address and data fan out to all banks, only the strobe is decoded
	always_comb
	begin
		for (int b = 0; b < `MEMCTL_BANKS; b++)
		begin
			bank[b].addr  = req.addr[`MEMCTL_BANK_ADDR_W-1:0];
			bank[b].wdata = req.wdata;
			bank[b].we    = en && req.wr && !boot_hit && (sel == SEL_W'(b));
		end
	end

	always_ff @(posedge CLK)
	begin
		if (rst)
		begin
			sel_q <= '0;
		end
		else if (en)
		begin
			sel_q <= sel; // follows the one-cycle bank latency
		end
	end

	// bank outputs are already registered, just pick one
	assign rdata = bank_rdata[sel_q];

endmodule

`default_nettype wire

//--- hdl/memory_controller.sv
//====================================================================
// shared memory controller top, four clients over four banks
// with a CPU-only boot overlay on the lowest 256 words
//====================================================================
`default_nettype none
`timescale 1ns/1ns

`include "memctl_consts.svh"

module memory_controller (
	input  wire logic                 CLK,
	input  wire logic                 rst,
	input  wire memctl_pkg::mem_req_t cpu_req,
	input  wire logic                 cpu_req_valid,
	output logic                      cpu_req_ready,
	output memctl_pkg::mem_rsp_t      cpu_rsp,
	output logic                      cpu_rsp_valid,
	input  wire memctl_pkg::mem_req_t spr_req,  // sprite fetcher
	input  wire logic                 spr_req_valid,
	output logic                      spr_req_ready,
	output memctl_pkg::mem_rsp_t      spr_rsp,
	output logic                      spr_rsp_valid,
	input  wire memctl_pkg::mem_req_t bg_req,   // background fetcher
	input  wire logic                 bg_req_valid,
	output logic                      bg_req_ready,
	output memctl_pkg::mem_rsp_t      bg_rsp,
	output logic                      bg_rsp_valid,
	input  wire memctl_pkg::mem_req_t fl_req,   // flash loader
	input  wire logic                 fl_req_valid,
	output logic                      fl_req_ready,
	output memctl_pkg::mem_rsp_t      fl_rsp,
	output logic                      fl_rsp_valid
);

	import memctl_pkg::*;

	logic [`MEMCTL_CLIENTS-1:0] req_valid, req_wr, req_ready, rsp_valid;
	client_idx_t grant, prio;
	logic        grant_valid, access_done, boot_hit, is_cpu;
	mem_req_t    req_sel; // granted client's request
	mem_rsp_t    rsp;     // shared by every client
	bank_port_t [`MEMCTL_BANKS-1:0] bank_port;
	logic [`MEMCTL_BANKS-1:0][`MEMCTL_DATA_W-1:0] bank_rdata;
	logic [`MEMCTL_DATA_W-1:0] router_rdata, rdata;

	// bit order matches the client numbers
	assign req_valid = {fl_req_valid, bg_req_valid, spr_req_valid, cpu_req_valid};
	assign req_wr    = {fl_req.wr, bg_req.wr, spr_req.wr, cpu_req.wr};

	always_comb
	begin
		case (grant)
			CLIENT_CPU:    req_sel = cpu_req;
			CLIENT_SPRITE: req_sel = spr_req;
			CLIENT_BG:     req_sel = bg_req;
			CLIENT_FLASH:  req_sel = fl_req;
			default:       req_sel = cpu_req;
		endcase
	end

	assign is_cpu = grant_valid && (grant == CLIENT_CPU); // overlay is cpu only

	arb_fsm arb0 (.CLK(CLK), .rst(rst), .req_valid(req_valid), .req_wr(req_wr),
		.prio(prio), .req_ready(req_ready), .rsp_valid(rsp_valid), .grant(grant),
		.grant_valid(grant_valid), .access_done(access_done));

	grant_rotator rot0 (.CLK(CLK), .rst(rst), .access_done(access_done),
		.grant(grant), .prio(prio));

	bank_router router0 (.CLK(CLK), .rst(rst), .req(req_sel), .en(grant_valid),
		.boot_hit(boot_hit), .bank(bank_port), .bank_rdata(bank_rdata),
		.rdata(router_rdata));

	mem_bank bank0 (.CLK(CLK), .port(bank_port[0]), .rdata(bank_rdata[0]));
	mem_bank bank1 (.CLK(CLK), .port(bank_port[1]), .rdata(bank_rdata[1]));
	mem_bank bank2 (.CLK(CLK), .port(bank_port[2]), .rdata(bank_rdata[2]));
	mem_bank bank3 (.CLK(CLK), .port(bank_port[3]), .rdata(bank_rdata[3]));

	boot_overlay boot0 (.CLK(CLK), .req(req_sel), .en(grant_valid), .is_cpu(is_cpu),
		.bank_rdata(router_rdata), .boot_hit(boot_hit), .rdata(rdata));

	assign rsp.rdata = rdata; // rsp_valid tells who owns it

	assign cpu_req_ready = req_ready[CLIENT_CPU];
	assign spr_req_ready = req_ready[CLIENT_SPRITE];
	assign bg_req_ready  = req_ready[CLIENT_BG];
	assign fl_req_ready  = req_ready[CLIENT_FLASH];

	assign cpu_rsp_valid = rsp_valid[CLIENT_CPU];
	assign spr_rsp_valid = rsp_valid[CLIENT_SPRITE];
	assign bg_rsp_valid  = rsp_valid[CLIENT_BG];
	assign fl_rsp_valid  = rsp_valid[CLIENT_FLASH]; // stays low, flash only writes

	assign cpu_rsp = rsp;
	assign spr_rsp = rsp;
	assign bg_rsp  = rsp;
	assign fl_rsp  = rsp;

endmodule

`default_nettype wire

//--- testbench/tb_clock.sv
//======================================================================
// clock and reset source for the memory controller testbench
// 8 ns period, reset held over the first two rising edges
//======================================================================
`default_nettype none
`timescale 1ns/1ns

module tb_clock (
	output logic CLK,
	output logic rst
);

	initial
	begin
		CLK = 1'b0;
		forever #4 CLK = ~CLK; // 8 ns period
	end

	initial
	begin
		rst = 1'b1;
		repeat (2) @(posedge CLK); // two reset cycles
		#1 rst = 1'b0;             // released like any other input
	end

endmodule

`default_nettype wire

//--- testbench/memory_controller_tb.sv
//======================================================================
// testbench for the memory controller, one test per patterns line
// drives the four client channels, checks grants, latency and data
//======================================================================
`default_nettype none
`timescale 1ns/1ns

module memory_controller_tb;

	import memctl_pkg::*;

	logic        CLK;
	logic        rst;
	mem_req_t    req_d [4];       // index = client number
	logic [3:0]  valid_d;
	logic        cpu_req_ready, spr_req_ready, bg_req_ready, fl_req_ready;
	logic        cpu_rsp_valid, spr_rsp_valid, bg_rsp_valid, fl_rsp_valid;
	mem_rsp_t    cpu_rsp, spr_rsp, bg_rsp, fl_rsp;
	logic [3:0]  ready_w;
	logic [3:0]  rsp_w;

	logic [7:0]  op_q [$];        // pattern columns
	logic [1:0]  cl_q [$];
	logic [15:0] addr_q [$];
	logic [15:0] wd_q [$];
	logic [15:0] ex_q [$];
	int          n_lines = 0;
	logic        loaded = 1'b0;

	logic [15:0] bank_model [int]; // last write per address
	logic [15:0] boot_model [int]; // cpu view of the low 256 words
	logic [15:0] exp_q [4];        // expected read data per client
	logic        exp_known [4];
	logic [31:0] lfsr = 32'h1d363b29;
	int          step_errs;
	int          n_pass = 0;
	int          n_fail = 0;

	tb_clock clk0 (.CLK(CLK), .rst(rst));

	memory_controller dut0 (
		.CLK(CLK), .rst(rst),
		.cpu_req(req_d[0]), .cpu_req_valid(valid_d[0]), .cpu_req_ready(cpu_req_ready),
		.cpu_rsp(cpu_rsp), .cpu_rsp_valid(cpu_rsp_valid),
		.spr_req(req_d[1]), .spr_req_valid(valid_d[1]), .spr_req_ready(spr_req_ready),
		.spr_rsp(spr_rsp), .spr_rsp_valid(spr_rsp_valid),
		.bg_req(req_d[2]), .bg_req_valid(valid_d[2]), .bg_req_ready(bg_req_ready),
		.bg_rsp(bg_rsp), .bg_rsp_valid(bg_rsp_valid),
		.fl_req(req_d[3]), .fl_req_valid(valid_d[3]), .fl_req_ready(fl_req_ready),
		.fl_rsp(fl_rsp), .fl_rsp_valid(fl_rsp_valid)
	);

	assign ready_w = {fl_req_ready, bg_req_ready, spr_req_ready, cpu_req_ready};
	assign rsp_w   = {fl_rsp_valid, bg_rsp_valid, spr_rsp_valid, cpu_rsp_valid};

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1); // galois, right shift
	endfunction

	// one lfsr step per data bit
	task automatic draw_word(output logic [15:0] w);
		for (int b = 0; b < 16; b++)
		begin
			w[b] = lfsr[0];
			lfsr = lfsr_next(lfsr);
		end
	endtask

	function automatic string client_name(input int c);
		case (c)
			0:       return "cpu";
			1:       return "spr";
			2:       return "bg";
			default: return "fl";
		endcase
	endfunction

	function automatic logic [15:0] rsp_data(input int c);
		case (c)
			0:       return cpu_rsp.rdata;
			1:       return spr_rsp.rdata;
			2:       return bg_rsp.rdata;
			default: return fl_rsp.rdata;
		endcase
	endfunction

	// cpu in the low 256 words sees boot memory, everyone else the banks
	task automatic model_write(input int c, input logic [15:0] a, input logic [15:0] d);
		if (c == 0 && a[15:8] == 8'h00)
			boot_model[int'(a)] = d;
		else
			bank_model[int'(a)] = d;
	endtask

	task automatic model_read(input int c, input logic [15:0] a, output logic known,
		output logic [15:0] d);
		known = 1'b0;
		d     = 16'h0;
		if (c == 0 && a[15:8] == 8'h00)
		begin
			known = boot_model.exists(int'(a));
			if (known)
				d = boot_model[int'(a)];
		end
		else if (bank_model.exists(int'(a)))
		begin
			known = 1'b1;
			d     = bank_model[int'(a)];
		end
	endtask

	// raise every client in act, follow the grants, check each response
	task automatic serve_round(input logic [3:0] act, input int first);
		logic [3:0] pending;
		logic [3:0] rdy;
		logic [3:0] rv;
		int         last;     // client accepted on the previous edge
		int         want;     // next client by round robin
		int         wait_cyc;
		int         lat;      // cycles from accept to rsp_valid
		int         c;
		pending  = act;
		last     = -1;
		want     = first;
		wait_cyc = 0;
		valid_d  = act;
		while ((pending != 4'b0 || last >= 0) && wait_cyc < 20)
		begin
			@(negedge CLK); // outputs settled here
			rdy = ready_w;
			rv  = rsp_w;
			if (last >= 0 && !req_d[last].wr)
			begin
				lat = 1;
				while (!rsp_w[last] && lat < 4) // a late response still gets counted
				begin
					@(negedge CLK);
					lat++;
				end
				rdy = ready_w;
				rv  = rsp_w;
				assert (rv == (4'b0001 << last) && lat == 1) else
				begin
					$display("no single response for client %0d one cycle after accept, %0d cycles",
						last, lat);
					step_errs++;
				end
				if (exp_known[last] && rv[last])
					assert (rsp_data(last) == exp_q[last]) else
					begin
						$display("[FAIL] %s_rsp.rdata: got %h, expected %h",
							client_name(last), rsp_data(last), exp_q[last]);
						step_errs++;
					end
			end
			else
				assert (rv == 4'b0) else
				begin
					$display("[FAIL] rsp_valid: got %h, expected %h", rv, 4'b0);
					step_errs++;
				end
			last = -1;
			if (rdy == 4'b0)
				wait_cyc++;
			else
			begin
				c = 0;
				for (int k = 0; k < 4; k++)
					if (rdy[k])
						c = k;
				assert ($onehot(rdy) && ((rdy & pending) != 4'b0)) else
				begin
					$display("req_ready raised for a client without a request");
					step_errs++;
				end
				assert (c == want) else
				begin
					$display("[FAIL] req_ready: got client %h, expected client %h", c, want);
					step_errs++;
				end
				want = (c + 1) % 4;    // search restarts after the served client
				@(posedge CLK);        // accept edge
				#1 valid_d[c] = 1'b0;
				pending[c] = 1'b0;
				if (req_d[c].wr)
					model_write(c, req_d[c].addr, req_d[c].wdata);
				last = c;
			end
		end
		assert (pending == 4'b0) else
		begin
			$display("no accept within 20 cycles, clients %h still waiting", pending);
			step_errs++;
		end
	endtask

	task automatic report_step(input string what);
		if (step_errs == 0)
		begin
			n_pass++;
			$display("%s: pass", what);
		end
		else
		begin
			n_fail++;
			$display("%s: fail, %0d errors", what, step_errs);
		end
	endtask

	initial
	begin
		int          fd;
		int          n;
		string       line;
		logic [7:0]  op;
		logic [1:0]  cl;
		logic [15:0] a, wd, ex, w0, w3;
		logic [3:0]  act;
		valid_d = 4'b0;
		for (int c = 0; c < 4; c++)
			req_d[c] = '0;
		fd = $fopen("testbench/memctl_patterns.txt", "r");
		assert (fd != 0) else
		begin
			$display("could not open the patterns file");
			n_fail++;
		end
		if (fd != 0)
		begin
			while ($fgets(line, fd) != 0)
			begin
				n = $sscanf(line, "%s %h %h %h %h", op, cl, a, wd, ex);
				if (n == 5) // comment lines stop after the first field
				begin
					op_q.push_back(op);
					cl_q.push_back(cl);
					addr_q.push_back(a);
					wd_q.push_back(wd);
					ex_q.push_back(ex);
				end
			end
			$fclose(fd);
		end
		n_lines = op_q.size();
		loaded  = 1'b1;

		wait (rst == 1'b0);
		step_errs = 0;
		repeat (3)
		begin
			@(negedge CLK);
			assert (ready_w == 4'b0 && rsp_w == 4'b0) else
			begin
				$display("[FAIL] req_ready/rsp_valid: got %h/%h, expected %h/%h",
					ready_w, rsp_w, 4'b0, 4'b0);
				step_errs++;
			end
		end
		report_step("reset idle");

		for (int i = 0; i < n_lines; i++)
		begin
			@(posedge CLK);
			#1 valid_d = 4'b0; // drops what a timed out round left raised
			step_errs = 0;
			op  = op_q[i];
			cl  = cl_q[i];
			a   = addr_q[i];
			wd  = wd_q[i];
			ex  = ex_q[i];
			act = 4'b0001 << cl;
			for (int c = 0; c < 4; c++)
				exp_known[c] = 1'b0;
			case (op)
				"W": req_d[cl] = '{addr: a, wdata: wd, wr: 1'b1};
				"R":
				begin
					req_d[cl] = '{addr: a, wdata: 16'h0, wr: 1'b0};
					model_read(int'(cl), a, exp_known[cl], exp_q[cl]);
					if (!exp_known[cl])
					begin
						exp_q[cl]     = ex; // never written here, file value
						exp_known[cl] = 1'b1;
					end
				end
				"P":
				begin
					draw_word(w0);
					draw_word(w3);
					req_d[0] = '{addr: a + 16'd1, wdata: w0, wr: 1'b1}; // cpu write
					req_d[1] = '{addr: wd, wdata: 16'h0, wr: 1'b0};     // sprite read
					req_d[2] = '{addr: ex, wdata: 16'h0, wr: 1'b0};     // bg read
					req_d[3] = '{addr: a, wdata: w3, wr: 1'b1};         // flash write
					model_read(1, wd, exp_known[1], exp_q[1]);
					model_read(2, ex, exp_known[2], exp_q[2]);
					act = 4'b1111;
				end
				default:
				begin
					$display("unknown operation on pattern line %0d", i);
					step_errs++;
					act = 4'b0;
				end
			endcase
			if (act != 4'b0)
				serve_round(act, int'(cl));
			report_step($sformatf("step %0d %s client %0d addr %h", i, op, cl, a));
		end

		$display("tests run %0d, passed %0d, failed %0d", n_pass + n_fail, n_pass, n_fail);
		if (n_fail == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

	// run length bound from the number of pattern lines
	initial
	begin
		wait (loaded);
		#((n_lines + 1) * 20 * 8);
		$display("timeout, run did not finish within %0d cycles", (n_lines + 1) * 20);
		$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- testbench/memctl_patterns.txt
// op client addr wdata expect, hex; client 0 cpu, 1 sprite, 2 bg, 3 flash
// P: client = first grant, flash writes addr, cpu addr+1, sprite reads wdata, bg reads expect
P 0 0500 0600 0700
P 0 4500 0500 0501
W 0 1234 a5a5 0000
R 0 1234 0000 a5a5
W 0 5678 1111 0000
R 0 5678 0000 1111
W 0 9abc 2222 0000
R 0 9abc 0000 2222
W 0 dead 3333 0000
R 0 dead 0000 3333
W 0 1234 5a5a 0000
R 0 1234 0000 5a5a
W 0 0010 b007 0000
W 3 0010 f1a5 0000
R 0 0010 0000 b007
R 1 0010 0000 f1a5
R 2 0010 0000 f1a5
P 3 8500 4500 4501
P 3 c500 8500 8501
R 2 1234 0000 5a5a
P 3 2500 c500 c501
R 1 dead 0000 3333
P 2 6500 2500 2501
R 0 0010 0000 b007
R 2 6500 0000 0000

//--- project.f
+incdir+include
hdl/memctl_pkg.sv
hdl/mem_bank.sv
hdl/boot_overlay.sv
hdl/grant_rotator.sv
hdl/arb_fsm.sv
hdl/bank_router.sv
hdl/memory_controller.sv
testbench/tb_clock.sv
testbench/memory_controller_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the testbench with Verilator and run it from the project root
# the run passes only if the testbench prints its pass message

verilator --binary --timing --assert -f project.f --top-module memory_controller_tb \
	&& ./obj_dir/Vmemory_controller_tb | tee /dev/stderr | grep "ALL TESTS PASSED" > /dev/null \
	&& echo "run_sim: simulation passed" \
	|| { echo "run_sim: simulation failed"; exit 1; }
